// File: Bender.yml
package:
  name: lpif_adapter

sources:
  # design, packages first
  - source/lpif_cfg_pkg.sv
  - source/lpif_flit_pkg.sv
  - source/lpif_dstrm_map.sv
  - source/lpif_link_ctl.sv
  - source/lpif_ustrm_map.sv
  - source/lpif_adapter_top.sv
  # testbench and bound checker
  - target: test
    files:
      - tests/lpif_adapter_assert.sv
      - tests/lpif_adapter_tb.sv

// File: flist.f
source/lpif_cfg_pkg.sv
source/lpif_flit_pkg.sv
source/lpif_dstrm_map.sv
source/lpif_link_ctl.sv
source/lpif_ustrm_map.sv
source/lpif_adapter_top.sv
tests/lpif_adapter_assert.sv
tests/lpif_adapter_tb.sv

// File: source/lpif_adapter_top.sv
`default_nettype none

module lpif_adapter_top #(
  parameter int unsigned               aib_lanes           = lpif_cfg_pkg::default_aib_lanes,
  parameter lpif_flit_pkg::stream_id_t mem_cache_stream_id = 8'h01,
  parameter lpif_flit_pkg::stream_id_t io_stream_id        = 8'h02,
  parameter lpif_flit_pkg::stream_id_t arb_mux_stream_id   = 8'h03
) (
  input  logic                       com_clk,
  input  logic                       rst_n,
  // link layer side
  input  logic                       lp_irdy,
  input  lpif_flit_pkg::lp_flit_t    lp_flit,
  output logic                       pl_trdy,
  output logic                       pl_valid,
  output lpif_flit_pkg::pl_flit_t    pl_flit,
  // adapter core side
  output logic                       dstrm_valid,
  output lpif_flit_pkg::dstrm_flit_t dstrm_flit,
  input  logic                       ustrm_valid,
  input  lpif_flit_pkg::ustrm_flit_t ustrm_flit,
  // AIB handshake
  input  logic                       i_conf_done,
  input  logic [aib_lanes-1:0]       ms_tx_transfer_en,
  input  logic [aib_lanes-1:0]       sl_tx_transfer_en,
  input  logic                       align_done,
  output logic                       ns_mac_rdy,
  output logic [aib_lanes-1:0]       ns_adapter_rstn,
  output logic                       tx_online,
  output logic                       rx_online,
  output logic                       ctl_link_up
);

  // link layer may send whenever the link is up
  assign pl_trdy = ctl_link_up;

  lpif_dstrm_map #(
    .mem_cache_stream_id(mem_cache_stream_id),
    .io_stream_id       (io_stream_id),
    .arb_mux_stream_id  (arb_mux_stream_id)
  ) u_dstrm_map (
    .com_clk    (com_clk),
    .rst_n      (rst_n),
    .link_up    (ctl_link_up),
    .lp_irdy    (lp_irdy),
    .lp_flit    (lp_flit),
    .dstrm_valid(dstrm_valid),
    .dstrm_flit (dstrm_flit)
  );

  lpif_link_ctl #(
    .aib_lanes(aib_lanes)
  ) u_link_ctl (
    .com_clk          (com_clk),
    .rst_n            (rst_n),
    .i_conf_done      (i_conf_done),
    .ms_tx_transfer_en(ms_tx_transfer_en),
    .sl_tx_transfer_en(sl_tx_transfer_en),
    .align_done       (align_done),
    .ns_mac_rdy       (ns_mac_rdy),
    .ns_adapter_rstn  (ns_adapter_rstn),
    .tx_online        (tx_online),
    .rx_online        (rx_online),
    .link_up          (ctl_link_up)
  );

  lpif_ustrm_map #(
    .mem_cache_stream_id(mem_cache_stream_id),
    .io_stream_id       (io_stream_id),
    .arb_mux_stream_id  (arb_mux_stream_id)
  ) u_ustrm_map (
    .com_clk    (com_clk),
    .rst_n      (rst_n),
    .link_up    (ctl_link_up),
    .ustrm_valid(ustrm_valid),
    .ustrm_flit (ustrm_flit),
    .pl_valid   (pl_valid),
    .pl_flit    (pl_flit)
  );

endmodule

`default_nettype wire

// File: source/lpif_cfg_pkg.sv
`default_nettype none

package lpif_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // link configuration
  ////////////////////////////////////////////////////////////////////////////

  // flit payload width in bytes, 512 data bits
  localparam int unsigned data_bytes = 64;

  // crc width that goes with the 64-byte flit
  localparam int unsigned crc_bits = 16;

  // AIB lane count when the top level does not override it
  localparam int unsigned default_aib_lanes = 4;

  ////////////////////////////////////////////////////////////////////////////
  // bring-up state machine
  ////////////////////////////////////////////////////////////////////////////

  // code 5 is unused and treated as illegal
  typedef enum logic [2:0] {
    idle          = 3'h0,
    phy_init      = 3'h1,
    cfg           = 3'h2,
    calib         = 3'h3,
    wait_ca_align = 3'h4,
    link_up       = 3'h6,
    halt          = 3'h7
  } ctl_state_e;

endpackage

`default_nettype wire

// File: source/lpif_dstrm_map.sv
`default_nettype none

module lpif_dstrm_map #(
  parameter lpif_flit_pkg::stream_id_t mem_cache_stream_id = 8'h01,
  parameter lpif_flit_pkg::stream_id_t io_stream_id        = 8'h02,
  parameter lpif_flit_pkg::stream_id_t arb_mux_stream_id   = 8'h03
) (
  input  logic                       com_clk,
  input  logic                       rst_n,
  input  logic                       link_up,
  input  logic                       lp_irdy,
  input  lpif_flit_pkg::lp_flit_t    lp_flit,
  output logic                       dstrm_valid,
  output lpif_flit_pkg::dstrm_flit_t dstrm_flit
);

  lpif_flit_pkg::protid_e protid;
  logic                   accept;

  // no back-pressure from the core, only the link state gates input
  assign accept = lp_irdy & link_up;

  // stream ID to protocol ID, unknown streams go to cache
  always_comb begin
    case (lp_flit.stream)
      mem_cache_stream_id: protid = lpif_flit_pkg::protid_cache;
      io_stream_id:        protid = lpif_flit_pkg::protid_io;
      arb_mux_stream_id:   protid = lpif_flit_pkg::protid_arb_mux;
      default:             protid = lpif_flit_pkg::protid_cache;
    endcase
  end

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      dstrm_valid <= 1'b0;
      dstrm_flit  <= '0;
    end else begin
      // one strobe per accepted flit
      dstrm_valid <= accept;
      // fields hold between accepted flits
      if (accept) begin
        dstrm_flit.data      <= lp_flit.data;
        dstrm_flit.valid     <= lp_flit.valid;
        dstrm_flit.crc       <= lp_flit.crc;
        dstrm_flit.crc_valid <= lp_flit.crc_valid;
        dstrm_flit.protid    <= protid;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/lpif_flit_pkg.sv
`default_nettype none

package lpif_flit_pkg;

  // LPIF stream identifier
  typedef logic [7:0] stream_id_t;

  // protocol ID carried towards the adapter core
  typedef enum logic [1:0] {
    protid_cache   = 2'd0,
    protid_io      = 2'd1,
    protid_arb_mux = 2'd2
  } protid_e;

  ////////////////////////////////////////////////////////////////////////////
  // flit layouts
  ////////////////////////////////////////////////////////////////////////////

  // link layer side, stream ID form
  typedef struct packed {
    logic [lpif_cfg_pkg::data_bytes*8-1:0] data;
    logic                                  valid;
    logic [lpif_cfg_pkg::crc_bits-1:0]     crc;
    logic                                  crc_valid;
    stream_id_t                            stream;
  } lp_flit_t;

  // core side, protocol ID form
  typedef struct packed {
    logic [lpif_cfg_pkg::data_bytes*8-1:0] data;
    logic                                  valid;
    logic [lpif_cfg_pkg::crc_bits-1:0]     crc;
    logic                                  crc_valid;
    protid_e                               protid;
  } dstrm_flit_t;

  // upstream flits use the same layouts in the other direction
  typedef dstrm_flit_t ustrm_flit_t;
  typedef lp_flit_t    pl_flit_t;

endpackage

`default_nettype wire

// File: source/lpif_link_ctl.sv
`default_nettype none

module lpif_link_ctl #(
  parameter int unsigned aib_lanes = 4
) (
  input  logic                 com_clk,
  input  logic                 rst_n,
  input  logic                 i_conf_done,
  input  logic [aib_lanes-1:0] ms_tx_transfer_en,
  input  logic [aib_lanes-1:0] sl_tx_transfer_en,
  input  logic                 align_done,
  output logic                 ns_mac_rdy,
  output logic [aib_lanes-1:0] ns_adapter_rstn,
  output logic                 tx_online,
  output logic                 rx_online,
  output logic                 link_up
);

  lpif_cfg_pkg::ctl_state_e state;
  lpif_cfg_pkg::ctl_state_e state_nxt;
  logic                     te_all;

  // calibration done once every lane reports transfer enable, both sides
  assign te_all = &{ms_tx_transfer_en, sl_tx_transfer_en};

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      lpif_cfg_pkg::idle: begin
        state_nxt = lpif_cfg_pkg::phy_init;
      end
      lpif_cfg_pkg::phy_init: begin
        if (i_conf_done) begin
          state_nxt = lpif_cfg_pkg::cfg;
        end
      end
      lpif_cfg_pkg::cfg: begin
        state_nxt = lpif_cfg_pkg::calib;
      end
      lpif_cfg_pkg::calib: begin
        if (te_all) begin
          state_nxt = lpif_cfg_pkg::wait_ca_align;
        end
      end
      lpif_cfg_pkg::wait_ca_align: begin
        if (align_done) begin
          state_nxt = lpif_cfg_pkg::link_up;
        end
      end
      // terminal states, left only through reset
      lpif_cfg_pkg::link_up: state_nxt = lpif_cfg_pkg::link_up;
      lpif_cfg_pkg::halt:    state_nxt = lpif_cfg_pkg::halt;
      default:               state_nxt = lpif_cfg_pkg::halt;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and handshake levels
  ////////////////////////////////////////////////////////////////////////////

  // each level is set on the edge that enters its state and then sticks
  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= lpif_cfg_pkg::idle;
      ns_mac_rdy      <= 1'b0;
      ns_adapter_rstn <= '0;
      tx_online       <= 1'b0;
      rx_online       <= 1'b0;
      link_up         <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state_nxt == lpif_cfg_pkg::cfg) begin
        ns_mac_rdy <= 1'b1;
      end
      // adapter out of reset on all lanes together
      if (state_nxt == lpif_cfg_pkg::calib) begin
        ns_adapter_rstn <= '1;
      end
      if (state_nxt == lpif_cfg_pkg::wait_ca_align) begin
        tx_online <= 1'b1;
        rx_online <= 1'b1;
      end
      if (state_nxt == lpif_cfg_pkg::link_up) begin
        link_up <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/lpif_ustrm_map.sv
`default_nettype none

module lpif_ustrm_map #(
  parameter lpif_flit_pkg::stream_id_t mem_cache_stream_id = 8'h01,
  parameter lpif_flit_pkg::stream_id_t io_stream_id        = 8'h02,
  parameter lpif_flit_pkg::stream_id_t arb_mux_stream_id   = 8'h03
) (
  input  logic                       com_clk,
  input  logic                       rst_n,
  input  logic                       link_up,
  input  logic                       ustrm_valid,
  input  lpif_flit_pkg::ustrm_flit_t ustrm_flit,
  output logic                       pl_valid,
  output lpif_flit_pkg::pl_flit_t    pl_flit
);

  lpif_flit_pkg::stream_id_t stream;
  logic                      fwd;

  // flits from the core are dropped until the link is up
  assign fwd = ustrm_valid & link_up;

  // protocol ID back to stream ID, spare code 3 goes to cache
  always_comb begin
    case (ustrm_flit.protid)
      lpif_flit_pkg::protid_cache:   stream = mem_cache_stream_id;
      lpif_flit_pkg::protid_io:      stream = io_stream_id;
      lpif_flit_pkg::protid_arb_mux: stream = arb_mux_stream_id;
      default:                       stream = mem_cache_stream_id;
    endcase
  end

  always_ff @(posedge com_clk or negedge rst_n) begin
    if (!rst_n) begin
      pl_valid <= 1'b0;
      pl_flit  <= '0;
    end else begin
      pl_valid <= fwd;
      // hold the last forwarded flit
      if (fwd) begin
        pl_flit.data      <= ustrm_flit.data;
        pl_flit.valid     <= ustrm_flit.valid;
        pl_flit.crc       <= ustrm_flit.crc;
        pl_flit.crc_valid <= ustrm_flit.crc_valid;
        pl_flit.stream    <= stream;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/lpif_adapter_assert.sv
`default_nettype none

module lpif_adapter_assert #(
  parameter int unsigned               aib_lanes           = 4,
  parameter lpif_flit_pkg::stream_id_t mem_cache_stream_id = 8'h01,
  parameter lpif_flit_pkg::stream_id_t io_stream_id        = 8'h02,
  parameter lpif_flit_pkg::stream_id_t arb_mux_stream_id   = 8'h03
) (
  input logic                       com_clk,
  input logic                       rst_n,
  input logic                       lp_irdy,
  input lpif_flit_pkg::lp_flit_t    lp_flit,
  input logic                       pl_trdy,
  input logic                       pl_valid,
  input lpif_flit_pkg::pl_flit_t    pl_flit,
  input logic                       dstrm_valid,
  input lpif_flit_pkg::dstrm_flit_t dstrm_flit,
  input logic                       ustrm_valid,
  input lpif_flit_pkg::ustrm_flit_t ustrm_flit,
  input logic                       i_conf_done,
  input logic [aib_lanes-1:0]       ms_tx_transfer_en,
  input logic [aib_lanes-1:0]       sl_tx_transfer_en,
  input logic                       align_done,
  input logic                       ns_mac_rdy,
  input logic [aib_lanes-1:0]       ns_adapter_rstn,
  input logic                       tx_online,
  input logic                       rx_online,
  input logic                       ctl_link_up
);
  timeunit 1ns;
  timeprecision 100ps;

  // protocol ID code to LPIF stream ID, spare code 3 goes to cache
  localparam lpif_flit_pkg::stream_id_t stream_of [4] = '{
    mem_cache_stream_id, io_stream_id, arb_mux_stream_id, mem_cache_stream_id
  };

  int unsigned                fail_cnt = 0;
  lpif_flit_pkg::protid_e     exp_protid;
  lpif_flit_pkg::dstrm_flit_t exp_dstrm;
  lpif_flit_pkg::pl_flit_t    exp_pl;
  logic                       te_all;
  logic                       stream_unknown;

  assign te_all         = &{ms_tx_transfer_en, sl_tx_transfer_en};
  assign stream_unknown = !(lp_flit.stream inside {mem_cache_stream_id, io_stream_id,
                                                   arb_mux_stream_id});

  // stream IDs without a parameter of their own land on cache
  assign exp_protid = (lp_flit.stream == io_stream_id)      ? lpif_flit_pkg::protid_io :
                      (lp_flit.stream == arb_mux_stream_id) ? lpif_flit_pkg::protid_arb_mux :
                                                              lpif_flit_pkg::protid_cache;

  // expected flits, one cycle behind the inputs
  always_ff @(posedge com_clk) begin
    exp_dstrm <= '{lp_flit.data, lp_flit.valid, lp_flit.crc, lp_flit.crc_valid, exp_protid};
    exp_pl    <= '{ustrm_flit.data, ustrm_flit.valid, ustrm_flit.crc, ustrm_flit.crc_valid,
                   stream_of[ustrm_flit.protid]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // bring-up
  ////////////////////////////////////////////////////////////////////////////

  a_reset: assert property (@(posedge com_clk) disable iff (!rst_n)
    !$past(rst_n) |-> {ns_mac_rdy, ns_adapter_rstn, tx_online, rx_online, ctl_link_up,
                       dstrm_valid, pl_valid} == '0 && dstrm_flit == '0 && pl_flit == '0) else begin
    $error("outputs not cleared after reset");
    fail_cnt++;
  end

  a_quiet: assert property (@(posedge com_clk) disable iff (!rst_n)
    !ctl_link_up |-> !dstrm_valid && !pl_valid && !pl_trdy) else begin
    $error("flit strobe or pl_trdy high before link up");
    fail_cnt++;
  end

  // each step one cycle after its condition
  a_steps: assert property (@(posedge com_clk) disable iff (!rst_n)
    (!ns_mac_rdy && i_conf_done |=> ns_mac_rdy) and
    ($rose(ns_mac_rdy) |=> &ns_adapter_rstn) and
    (&ns_adapter_rstn && te_all |=> tx_online && rx_online) and
    (tx_online && align_done |=> ctl_link_up)) else begin
    $error("bring-up step late or out of order");
    fail_cnt++;
  end

  a_sticky: assert property (@(posedge com_clk) disable iff (!rst_n)
    !$fell(ns_mac_rdy) && !$fell(&ns_adapter_rstn) && !$fell(tx_online) &&
    !$fell(rx_online) && !$fell(ctl_link_up)) else begin
    $error("handshake level dropped before reset");
    fail_cnt++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // flit paths
  ////////////////////////////////////////////////////////////////////////////

  a_dstrm: assert property (@(posedge com_clk) disable iff (!rst_n)
    lp_irdy && pl_trdy |=> dstrm_valid && dstrm_flit == exp_dstrm) else begin
    $error("Mismatch downstream flit: expected %h actual %h",
           $sampled({1'b1, exp_dstrm}), $sampled({dstrm_valid, dstrm_flit}));
    fail_cnt++;
  end

  a_unknown: assert property (@(posedge com_clk) disable iff (!rst_n)
    lp_irdy && pl_trdy && stream_unknown |=> dstrm_flit.protid == lpif_flit_pkg::protid_cache)
  else begin
    $error("Mismatch unknown stream protid: expected %0d actual %0d",
           lpif_flit_pkg::protid_cache, $sampled(dstrm_flit.protid));
    fail_cnt++;
  end

  a_ustrm: assert property (@(posedge com_clk) disable iff (!rst_n)
    ustrm_valid && ctl_link_up |=> pl_valid && pl_flit == exp_pl) else begin
    $error("Mismatch upstream flit: expected %h actual %h",
           $sampled({1'b1, exp_pl}), $sampled({pl_valid, pl_flit}));
    fail_cnt++;
  end

  a_drop: assert property (@(posedge com_clk) disable iff (!rst_n)
    (lp_irdy || ustrm_valid) && !pl_trdy |=> !dstrm_valid && !pl_valid) else begin
    $error("flit offered before link up was passed on");
    fail_cnt++;
  end

endmodule

bind lpif_adapter_top lpif_adapter_assert #(
  .aib_lanes          (aib_lanes),
  .mem_cache_stream_id(mem_cache_stream_id),
  .io_stream_id       (io_stream_id),
  .arb_mux_stream_id  (arb_mux_stream_id)
) u_adapter_assert (.*);

`default_nettype wire

// File: tests/lpif_adapter_tb.sv
`default_nettype none

module lpif_adapter_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned aib_lanes  = lpif_cfg_pkg::default_aib_lanes;
  localparam int unsigned wait_limit = 64;

  logic                       com_clk = 1'b0;
  logic                       rst_n;
  logic                       lp_irdy;
  lpif_flit_pkg::lp_flit_t    lp_flit;
  logic                       pl_trdy;
  logic                       pl_valid;
  lpif_flit_pkg::pl_flit_t    pl_flit;
  logic                       dstrm_valid;
  lpif_flit_pkg::dstrm_flit_t dstrm_flit;
  logic                       ustrm_valid;
  lpif_flit_pkg::ustrm_flit_t ustrm_flit;
  logic                       i_conf_done;
  logic [aib_lanes-1:0]       ms_tx_transfer_en;
  logic [aib_lanes-1:0]       sl_tx_transfer_en;
  logic                       align_done;
  logic                       ns_mac_rdy;
  logic [aib_lanes-1:0]       ns_adapter_rstn;
  logic                       tx_online;
  logic                       rx_online;
  logic                       ctl_link_up;
  logic [3:0]                 up_flags;
  integer                     seed;
  int unsigned                timeout_cnt;
  int unsigned                assert_cnt;

  lpif_adapter_top #(.aib_lanes(aib_lanes)) u_lpif_adapter_top (.*);

  always #5 com_clk = ~com_clk;

  // bring-up milestones in order
  assign up_flags = {ctl_link_up, tx_online & rx_online, &ns_adapter_rstn, ns_mac_rdy};

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic lpif_flit_pkg::lp_flit_t rand_lp_flit();
    lpif_flit_pkg::lp_flit_t f;
    logic [31:0]             r;
    for (int i = 0; i < lpif_cfg_pkg::data_bytes / 4; i++) begin
      f.data[i*32 +: 32] = $random(seed);
    end
    r           = $random(seed);
    f.valid     = r[0];
    f.crc_valid = r[1];
    f.crc       = r[31 -: lpif_cfg_pkg::crc_bits];
    f.stream    = r[15:8];
    // upper half folds onto the known IDs, lower half mostly unknown
    if (f.stream[7]) begin
      f.stream = 8'd1 + 8'(f.stream[6:0] % 7'd3);
    end
    return f;
  endfunction

  function automatic lpif_flit_pkg::ustrm_flit_t rand_ustrm_flit();
    lpif_flit_pkg::lp_flit_t f;
    f = rand_lp_flit();
    // all four codes, spare code 3 too
    return '{f.data, f.valid, f.crc, f.crc_valid, lpif_flit_pkg::protid_e'(f.stream[1:0])};
  endfunction

  task automatic drive_traffic(input int unsigned cycles);
    repeat (cycles) begin
      @(posedge com_clk);
      lp_irdy     <= 1'($random(seed));
      lp_flit     <= rand_lp_flit();
      ustrm_valid <= 1'($random(seed));
      ustrm_flit  <= rand_ustrm_flit();
    end
    @(posedge com_clk);
    lp_irdy     <= 1'b0;
    ustrm_valid <= 1'b0;
  endtask

  task automatic idle_cycles(input int unsigned max_cycles);
    repeat (1 + ($unsigned($random(seed)) % max_cycles)) @(posedge com_clk);
  endtask

  task automatic wait_milestone(input int idx, input string what);
    int unsigned n;
    n = 0;
    while (!up_flags[idx] && n < wait_limit) begin
      @(posedge com_clk);
      n++;
    end
    if (!up_flags[idx]) begin
      $display("timeout: %s not reached within %0d cycles", what, wait_limit);
      timeout_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed              = 71368;
    timeout_cnt       = 0;
    rst_n             = 1'b0;
    lp_irdy           = 1'b0;
    lp_flit           = '0;
    ustrm_valid       = 1'b0;
    ustrm_flit        = '0;
    i_conf_done       = 1'b0;
    ms_tx_transfer_en = '0;
    sl_tx_transfer_en = '0;
    align_done        = 1'b0;
    repeat (2) @(posedge com_clk);
    rst_n <= 1'b1;

    // link still down, all of this is dropped
    drive_traffic(8);
    // flits stay offered across the link-up edge
    lp_irdy     <= 1'b1;
    ustrm_valid <= 1'b1;

    idle_cycles(4);
    i_conf_done <= 1'b1;
    wait_milestone(0, "ns_mac_rdy");
    wait_milestone(1, "ns_adapter_rstn release");
    // lanes report transfer enable one at a time
    for (int i = 0; i < aib_lanes; i++) begin
      idle_cycles(3);
      ms_tx_transfer_en[i]             <= 1'b1;
      sl_tx_transfer_en[aib_lanes-1-i] <= 1'b1;
    end
    wait_milestone(2, "tx and rx online");
    idle_cycles(4);
    align_done <= 1'b1;
    wait_milestone(3, "link up");

    drive_traffic(200);
    repeat (2) @(posedge com_clk);

    assert_cnt = u_lpif_adapter_top.u_adapter_assert.fail_cnt;
    $display("assertion errors: %0d, timeouts: %0d", assert_cnt, timeout_cnt);
    if (assert_cnt == 0 && timeout_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
